//--- list.f
hw/soc_bus_pkg.sv
hw/axi_addr_decode.sv
hw/axi_xbar.sv
hw/axi_sram.sv
hw/axi_uart.sv
hw/axi_clint.sv
hw/soc_bus_top.sv
testbench/soc_bus_checker.sv
testbench/tb_soc_bus.sv

//--- run.sh
#!/bin/sh
# build and run the soc bus testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
	--top-module tb_soc_bus -Mdir obj_dir -o tb_soc_bus -f list.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_soc_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test completed successfully" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- testbench/tb_soc_bus.sv
// testbench top: clock, reset, axi-lite master tasks, directed and random traffic, watchdog
`default_nettype none

module tb_soc_bus import soc_bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int SRAM_WORDS = 256;
	localparam int NUM_RAND   = 200;
	localparam int NUM_TXN    = SRAM_WORDS + 40 + 4 * NUM_RAND;	// directed plus random pairs

	logic        clk;
	logic        rst_n;
	logic [31:0] cpu_ar_addr, cpu_aw_addr, cpu_w_data, cpu_r_data;
	logic        cpu_ar_valid, cpu_ar_ready, cpu_r_valid, cpu_r_ready;
	logic        cpu_aw_valid, cpu_aw_ready, cpu_w_valid, cpu_w_ready;
	logic [3:0]  cpu_w_strb;
	logic [1:0]  cpu_r_resp, cpu_b_resp;
	logic        cpu_b_valid, cpu_b_ready;
	logic [7:0]  uart_tx_data;
	logic        uart_tx_valid;
	int          err_count, check_count;

	soc_bus_top #(.ADDR_LEN(32), .DATA_LEN(32), .SRAM_WORDS(SRAM_WORDS)) UUT (
		.clk(clk), .rst_n_i(rst_n),
		.cpu_ar_addr_i(cpu_ar_addr), .cpu_ar_valid_i(cpu_ar_valid), .cpu_ar_ready_o(cpu_ar_ready),
		.cpu_r_data_o(cpu_r_data), .cpu_r_resp_o(cpu_r_resp), .cpu_r_valid_o(cpu_r_valid),
		.cpu_r_ready_i(cpu_r_ready),
		.cpu_aw_addr_i(cpu_aw_addr), .cpu_aw_valid_i(cpu_aw_valid), .cpu_aw_ready_o(cpu_aw_ready),
		.cpu_w_data_i(cpu_w_data), .cpu_w_strb_i(cpu_w_strb), .cpu_w_valid_i(cpu_w_valid),
		.cpu_w_ready_o(cpu_w_ready),
		.cpu_b_resp_o(cpu_b_resp), .cpu_b_valid_o(cpu_b_valid), .cpu_b_ready_i(cpu_b_ready),
		.uart_tx_data_o(uart_tx_data), .uart_tx_valid_o(uart_tx_valid)
	);

	soc_bus_checker #(.SRAM_WORDS(SRAM_WORDS)) u_check (
		.clk(clk), .rst_n_i(rst_n),
		.ar_addr_i(cpu_ar_addr), .ar_valid_i(cpu_ar_valid), .ar_ready_i(cpu_ar_ready),
		.r_data_i(cpu_r_data), .r_resp_i(cpu_r_resp), .r_valid_i(cpu_r_valid),
		.r_ready_i(cpu_r_ready),
		.aw_addr_i(cpu_aw_addr), .aw_valid_i(cpu_aw_valid), .aw_ready_i(cpu_aw_ready),
		.w_data_i(cpu_w_data), .w_strb_i(cpu_w_strb), .w_valid_i(cpu_w_valid),
		.w_ready_i(cpu_w_ready),
		.b_resp_i(cpu_b_resp), .b_valid_i(cpu_b_valid), .b_ready_i(cpu_b_ready),
		.tx_data_i(uart_tx_data), .tx_valid_i(uart_tx_valid),
		.err_count_o(err_count), .check_count_o(check_count)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// sram fill value, every address bit counts
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr ^ (addr << 13) ^ 32'h6b3c_0000;
	endfunction

	function automatic logic [31:0] pick_addr();
		int sel;
		sel = int'($urandom % 8);
		case (sel)
			0, 1, 2, 3: return SRAM_BASE + 4 * ($urandom % SRAM_WORDS);
			4: return UART_TX_ADDR;
			5: return CLINT_MTIME_LO;
			6: return CLINT_MTIME_HI;
			default: return ($urandom % 2) ? SRAM_BASE + 4 * SRAM_WORDS : 32'h0000_0100;
		endcase
	endfunction

	// starts and ends 1 ns after a rising edge, handshakes judged mid-cycle
	task automatic send_read_addr(input logic [31:0] addr);
		cpu_ar_addr  = addr;
		cpu_ar_valid = 1'b1;
		#2;
		while (!cpu_ar_ready) begin
			@(posedge clk);
			#3;
		end
		@(posedge clk);
		#1;
		cpu_ar_valid = 1'b0;
	endtask

	task automatic take_read_resp();
		cpu_r_ready = ($urandom % 4) != 0;	// random back-pressure
		#2;
		while (!(cpu_r_valid && cpu_r_ready)) begin
			@(posedge clk);
			#1;
			cpu_r_ready = ($urandom % 4) != 0;
			#2;
		end
		@(posedge clk);
		#1;
		cpu_r_ready = 1'b0;
	endtask

	task automatic read_bus(input logic [31:0] addr);
		send_read_addr(addr);
		take_read_resp();
	endtask

	// second address waits on the bus while the first response is still owed
	task automatic read_overlap(input logic [31:0] addr_a, input logic [31:0] addr_b);
		send_read_addr(addr_a);
		fork
			send_read_addr(addr_b);
			begin
				take_read_resp();
				take_read_resp();
			end
		join
	endtask

	task automatic send_write_req(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		cpu_aw_addr  = addr;
		cpu_w_data   = data;
		cpu_w_strb   = strb;
		cpu_aw_valid = 1'b1;	// aw and w go together
		cpu_w_valid  = 1'b1;
		#2;
		while (!(cpu_aw_ready && cpu_w_ready)) begin
			@(posedge clk);
			#3;
		end
		@(posedge clk);
		#1;
		cpu_aw_valid = 1'b0;
		cpu_w_valid  = 1'b0;
	endtask

	task automatic take_write_resp();
		cpu_b_ready = ($urandom % 4) != 0;
		#2;
		while (!(cpu_b_valid && cpu_b_ready)) begin
			@(posedge clk);
			#1;
			cpu_b_ready = ($urandom % 4) != 0;
			#2;
		end
		@(posedge clk);
		#1;
		cpu_b_ready = 1'b0;
	endtask

	task automatic write_bus(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		send_write_req(addr, data, strb);
		take_write_resp();
	endtask

	task automatic write_overlap(input logic [31:0] addr_a, input logic [31:0] data_a,
		input logic [3:0] strb_a, input logic [31:0] addr_b, input logic [31:0] data_b,
		input logic [3:0] strb_b);
		send_write_req(addr_a, data_a, strb_a);
		fork
			send_write_req(addr_b, data_b, strb_b);
			begin
				take_write_resp();
				take_write_resp();
			end
		join
	endtask

	initial begin
		logic [31:0] addr;
		void'($urandom(78054));
		rst_n        = 1'b0;
		cpu_ar_addr  = '0;
		cpu_ar_valid = 1'b0;
		cpu_r_ready  = 1'b0;
		cpu_aw_addr  = '0;
		cpu_aw_valid = 1'b0;
		cpu_w_data   = '0;
		cpu_w_strb   = '0;
		cpu_w_valid  = 1'b0;
		cpu_b_ready  = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(posedge clk);
		#1;

		// fill the whole sram, then spot reads
		for (int i = 0; i < SRAM_WORDS; i++) begin
			addr = SRAM_BASE + 4 * i;
			write_bus(addr, fill_word(addr), 4'hf);
		end
		for (int i = 0; i < 8; i++) begin
			read_bus(SRAM_BASE + 4 * (i * 31 % SRAM_WORDS));
		end

		// partial strobes, zero strobe included
		write_bus(SRAM_BASE + 32'h40, 32'h1122_3344, 4'b0001);
		read_bus(SRAM_BASE + 32'h40);
		write_bus(SRAM_BASE + 32'h44, 32'h5566_7788, 4'b0110);
		read_bus(SRAM_BASE + 32'h44);
		write_bus(SRAM_BASE + 32'h48, 32'h99aa_bbcc, 4'b1000);
		read_bus(SRAM_BASE + 32'h48);
		write_bus(SRAM_BASE + 32'h4c, 32'hddee_ff00, 4'b1010);
		read_bus(SRAM_BASE + 32'h4c);
		write_bus(SRAM_BASE + 32'h50, 32'hffff_ffff, 4'b0000);
		read_bus(SRAM_BASE + 32'h50);

		// uart, strobes have no effect on the byte
		write_bus(UART_TX_ADDR, 32'hdead_be41, 4'h0);
		write_bus(UART_TX_ADDR, 32'h0000_0a0d, 4'h1);
		read_bus(UART_TX_ADDR);

		read_bus(CLINT_MTIME_LO);
		read_bus(CLINT_MTIME_LO);
		read_bus(CLINT_MTIME_HI);
		write_bus(CLINT_MTIME_LO, 32'h1234_5678, 4'hf);

		// unmapped, one just past the sram window
		write_bus(SRAM_BASE + 4 * SRAM_WORDS, 32'hbad0_0001, 4'hf);
		read_bus(SRAM_BASE + 4 * SRAM_WORDS);
		write_bus(32'h0000_0100, 32'hbad0_0002, 4'hf);
		read_bus(32'ha000_0000);
		read_bus(SRAM_BASE);	// must still hold its fill value

		for (int n = 0; n < NUM_RAND; n++) begin
			fork
				read_overlap(pick_addr(), pick_addr());
				write_overlap(pick_addr(), $urandom, 4'($urandom),
					pick_addr(), $urandom, 4'($urandom));
			join
		end

		repeat (3) @(posedge clk);
		$display("Checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#((NUM_TXN * 40 + 100) * 8);
		$display("Timeout: the bus stopped answering before all transactions were done");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/soc_bus_checker.sv
// bus checker: reference sram model, expected responses, latency, ordering and uart checks
`default_nettype none

module soc_bus_checker import soc_bus_pkg::*; #(
	parameter int SRAM_WORDS = 256
) (
	input  logic        clk,
	input  logic        rst_n_i,
	input  logic [31:0] ar_addr_i,
	input  logic        ar_valid_i,
	input  logic        ar_ready_i,
	input  logic [31:0] r_data_i,
	input  logic [1:0]  r_resp_i,
	input  logic        r_valid_i,
	input  logic        r_ready_i,
	input  logic [31:0] aw_addr_i,
	input  logic        aw_valid_i,
	input  logic        aw_ready_i,
	input  logic [31:0] w_data_i,
	input  logic [3:0]  w_strb_i,
	input  logic        w_valid_i,
	input  logic        w_ready_i,
	input  logic [1:0]  b_resp_i,
	input  logic        b_valid_i,
	input  logic        b_ready_i,
	input  logic [7:0]  tx_data_i,
	input  logic        tx_valid_i,
	output int          err_count_o,
	output int          check_count_o
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] model [int];	// sram words written so far
	int          errors = 0;
	int          checks = 0;
	logic [63:0] mt = '0;		// mtime as the clint holds it this cycle
	bit          rst_low_last = 1'b1;
	bit          rd_pend = 1'b0, wr_pend = 1'b0, tx_due = 1'b0;
	bit          rd_check_data, rd_is_lo, have_lo = 1'b0;
	logic [31:0] rd_addr, rd_exp_data, wr_addr, last_lo;
	logic [1:0]  rd_exp_resp, wr_exp_resp;
	logic [7:0]  tx_exp;

	assign err_count_o   = errors;
	assign check_count_o = checks;

	// which slave serves this access, DEV_NONE means decerr
	function automatic dev_t slave_for(input logic [31:0] addr, input bit is_wr);
		logic [31:0] off;
		off = addr - SRAM_BASE;
		if (addr >= SRAM_BASE && off < 4 * SRAM_WORDS)
			return DEV_SRAM;
		if (is_wr && addr == UART_TX_ADDR)
			return DEV_UART;
		if (!is_wr && (addr == CLINT_MTIME_LO || addr == CLINT_MTIME_HI))
			return DEV_CLINT;
		return DEV_NONE;
	endfunction

	task automatic flag_error(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	// mid-cycle sampling, inputs and outputs are settled here
	always @(negedge clk) begin
		int          ridx;
		int          widx;
		dev_t        tgt;
		logic [31:0] word;
		mt = rst_low_last ? 64'd0 : mt + 64'd1;
		rst_low_last = !rst_n_i;
		if (!rst_n_i) begin
			rd_pend = 1'b0;
			wr_pend = 1'b0;
			tx_due  = 1'b0;
		end else begin
			if (ar_ready_i && !ar_valid_i)
				flag_error("read address ready raised without a valid");
			if ((aw_ready_i || w_ready_i) && !(aw_valid_i && w_valid_i))
				flag_error("write ready raised without both valids");

			// read channel, response side first
			if (rd_pend && !r_valid_i)
				flag_error($sformatf("read %h response late or dropped before ready", rd_addr));
			if (r_valid_i && !rd_pend)
				flag_error("read response with no read open");
			if (r_valid_i && r_ready_i && rd_pend) begin
				checks++;
				if (r_resp_i !== rd_exp_resp)
					flag_error($sformatf("read %h resp %0d, expected %0d", rd_addr, r_resp_i,
						rd_exp_resp));
				else if (rd_check_data && r_data_i !== rd_exp_data)
					flag_error($sformatf("read %h data %h, expected %h", rd_addr, r_data_i,
						rd_exp_data));
				if (rd_is_lo) begin
					if (have_lo && r_data_i <= last_lo)
						flag_error($sformatf("mtime low %h not above previous %h", r_data_i, last_lo));
					last_lo = r_data_i;
					have_lo = 1'b1;
				end
				rd_pend = 1'b0;
			end
			if (ar_valid_i && ar_ready_i) begin
				if (rd_pend)
					flag_error("second read accepted before the first response");
				tgt           = slave_for(ar_addr_i, 1'b0);
				rd_pend       = 1'b1;
				rd_addr       = ar_addr_i;
				rd_exp_resp   = (tgt == DEV_NONE) ? RESP_DECERR : RESP_OKAY;
				rd_exp_data   = '0;	// decerr reads give zero
				rd_check_data = 1'b1;
				rd_is_lo      = 1'b0;
				if (tgt == DEV_SRAM) begin
					ridx          = int'((ar_addr_i - SRAM_BASE) >> 2);
					rd_check_data = model.exists(ridx);
					if (rd_check_data)
						rd_exp_data = model[ridx];
				end else if (tgt == DEV_CLINT) begin
					rd_is_lo    = (ar_addr_i == CLINT_MTIME_LO);
					rd_exp_data = rd_is_lo ? mt[31:0] : mt[63:32];
				end
			end

			// write channel and uart strobe
			if (wr_pend && !b_valid_i)
				flag_error($sformatf("write %h response late or dropped before ready", wr_addr));
			if (b_valid_i && !wr_pend)
				flag_error("write response with no write open");
			if (tx_valid_i !== tx_due)
				flag_error("uart strobe does not match the accepted writes");
			else if (tx_due && tx_data_i !== tx_exp)
				flag_error($sformatf("uart byte %h, expected %h", tx_data_i, tx_exp));
			if (tx_due)
				checks++;
			tx_due = 1'b0;
			if (b_valid_i && b_ready_i && wr_pend) begin
				checks++;
				if (b_resp_i !== wr_exp_resp)
					flag_error($sformatf("write %h resp %0d, expected %0d", wr_addr, b_resp_i,
						wr_exp_resp));
				wr_pend = 1'b0;
			end
			if (aw_valid_i && aw_ready_i) begin
				if (!(w_valid_i && w_ready_i))
					flag_error("write address accepted without its data");
				if (wr_pend)
					flag_error("second write accepted before the first response");
				tgt         = slave_for(aw_addr_i, 1'b1);
				wr_pend     = 1'b1;
				wr_addr     = aw_addr_i;
				wr_exp_resp = (tgt == DEV_NONE) ? RESP_DECERR : RESP_OKAY;
				if (tgt == DEV_SRAM) begin
					widx = int'((aw_addr_i - SRAM_BASE) >> 2);
					word = model.exists(widx) ? model[widx] : 32'h0;
					for (int b = 0; b < 4; b++) begin
						if (w_strb_i[b])
							word[8*b +: 8] = w_data_i[8*b +: 8];
					end
					if (model.exists(widx) || w_strb_i == 4'hf)
						model[widx] = word;	// partial write of an unknown word stays unknown
				end else if (tgt == DEV_UART) begin
					tx_due = 1'b1;
					tx_exp = w_data_i[7:0];
				end
			end else if (w_valid_i && w_ready_i) begin
				flag_error("write data accepted without its address");
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/soc_bus_top.sv
// soc bus top: decoder, crossbar, sram, uart and clint wired together
`default_nettype none

module soc_bus_top import soc_bus_pkg::*; #(
	parameter int ADDR_LEN   = 32,
	parameter int DATA_LEN   = 32,
	parameter int SRAM_WORDS = 256
) (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic [ADDR_LEN-1:0]   cpu_ar_addr_i,
	input  logic                  cpu_ar_valid_i,
	output logic                  cpu_ar_ready_o,
	output logic [DATA_LEN-1:0]   cpu_r_data_o,
	output logic [1:0]            cpu_r_resp_o,
	output logic                  cpu_r_valid_o,
	input  logic                  cpu_r_ready_i,
	input  logic [ADDR_LEN-1:0]   cpu_aw_addr_i,
	input  logic                  cpu_aw_valid_i,
	output logic                  cpu_aw_ready_o,
	input  logic [DATA_LEN-1:0]   cpu_w_data_i,
	input  logic [DATA_LEN/8-1:0] cpu_w_strb_i,
	input  logic                  cpu_w_valid_i,
	output logic                  cpu_w_ready_o,
	output logic [1:0]            cpu_b_resp_o,
	output logic                  cpu_b_valid_o,
	input  logic                  cpu_b_ready_i,
	output logic [7:0]            uart_tx_data_o,
	output logic                  uart_tx_valid_o
);

	dev_t                  rd_dev, wr_dev;
	logic [ADDR_LEN-1:0]   sram_ar_addr, sram_aw_addr, clint_ar_addr;
	logic                  sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
	logic [DATA_LEN-1:0]   sram_r_data, sram_w_data;
	logic [1:0]            sram_r_resp, sram_b_resp;
	logic                  sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
	logic [DATA_LEN/8-1:0] sram_w_strb;
	logic                  sram_b_valid, sram_b_ready;
	logic                  uart_aw_valid, uart_aw_ready, uart_w_valid, uart_w_ready;
	logic [DATA_LEN-1:0]   uart_w_data;
	logic [1:0]            uart_b_resp;
	logic                  uart_b_valid, uart_b_ready;
	logic                  clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;
	logic [DATA_LEN-1:0]   clint_r_data;
	logic [1:0]            clint_r_resp;

	// decoder watches the master-side handshakes
	axi_addr_decode #(.ADDR_LEN(ADDR_LEN), .SRAM_WORDS(SRAM_WORDS)) u_decode (
		.clk(clk), .rst_n_i(rst_n_i),
		.ar_addr_i(cpu_ar_addr_i), .ar_valid_i(cpu_ar_valid_i), .ar_ready_i(cpu_ar_ready_o),
		.r_valid_i(cpu_r_valid_o), .r_ready_i(cpu_r_ready_i),
		.aw_addr_i(cpu_aw_addr_i), .aw_valid_i(cpu_aw_valid_i), .aw_ready_i(cpu_aw_ready_o),
		.b_valid_i(cpu_b_valid_o), .b_ready_i(cpu_b_ready_i),
		.rd_dev_o(rd_dev), .wr_dev_o(wr_dev)
	);

	axi_xbar #(.ADDR_LEN(ADDR_LEN), .DATA_LEN(DATA_LEN)) u_xbar (
		.clk(clk), .rst_n_i(rst_n_i),
		.cpu_ar_addr_i, .cpu_ar_valid_i, .cpu_ar_ready_o,
		.cpu_r_data_o, .cpu_r_resp_o, .cpu_r_valid_o, .cpu_r_ready_i,
		.cpu_aw_addr_i, .cpu_aw_valid_i, .cpu_aw_ready_o,
		.cpu_w_data_i, .cpu_w_strb_i, .cpu_w_valid_i, .cpu_w_ready_o,
		.cpu_b_resp_o, .cpu_b_valid_o, .cpu_b_ready_i,
		.rd_dev_i(rd_dev), .wr_dev_i(wr_dev),
		.sram_ar_addr_o(sram_ar_addr), .sram_ar_valid_o(sram_ar_valid),
		.sram_ar_ready_i(sram_ar_ready), .sram_r_data_i(sram_r_data),
		.sram_r_resp_i(sram_r_resp), .sram_r_valid_i(sram_r_valid),
		.sram_r_ready_o(sram_r_ready), .sram_aw_addr_o(sram_aw_addr),
		.sram_aw_valid_o(sram_aw_valid), .sram_aw_ready_i(sram_aw_ready),
		.sram_w_data_o(sram_w_data), .sram_w_strb_o(sram_w_strb),
		.sram_w_valid_o(sram_w_valid), .sram_w_ready_i(sram_w_ready),
		.sram_b_resp_i(sram_b_resp), .sram_b_valid_i(sram_b_valid),
		.sram_b_ready_o(sram_b_ready),
		.uart_aw_valid_o(uart_aw_valid), .uart_aw_ready_i(uart_aw_ready),
		.uart_w_data_o(uart_w_data), .uart_w_valid_o(uart_w_valid),
		.uart_w_ready_i(uart_w_ready), .uart_b_resp_i(uart_b_resp),
		.uart_b_valid_i(uart_b_valid), .uart_b_ready_o(uart_b_ready),
		.clint_ar_addr_o(clint_ar_addr), .clint_ar_valid_o(clint_ar_valid),
		.clint_ar_ready_i(clint_ar_ready), .clint_r_data_i(clint_r_data),
		.clint_r_resp_i(clint_r_resp), .clint_r_valid_i(clint_r_valid),
		.clint_r_ready_o(clint_r_ready)
	);

	axi_sram #(.ADDR_LEN(ADDR_LEN), .DATA_LEN(DATA_LEN), .SRAM_WORDS(SRAM_WORDS)) u_sram (
		.clk(clk), .rst_n_i(rst_n_i),
		.ar_addr_i(sram_ar_addr), .ar_valid_i(sram_ar_valid), .ar_ready_o(sram_ar_ready),
		.r_data_o(sram_r_data), .r_resp_o(sram_r_resp), .r_valid_o(sram_r_valid),
		.r_ready_i(sram_r_ready),
		.aw_addr_i(sram_aw_addr), .aw_valid_i(sram_aw_valid), .aw_ready_o(sram_aw_ready),
		.w_data_i(sram_w_data), .w_strb_i(sram_w_strb), .w_valid_i(sram_w_valid),
		.w_ready_o(sram_w_ready),
		.b_resp_o(sram_b_resp), .b_valid_o(sram_b_valid), .b_ready_i(sram_b_ready)
	);

	axi_uart #(.DATA_LEN(DATA_LEN)) u_uart (
		.clk(clk), .rst_n_i(rst_n_i),
		.aw_valid_i(uart_aw_valid), .aw_ready_o(uart_aw_ready),
		.w_data_i(uart_w_data), .w_valid_i(uart_w_valid), .w_ready_o(uart_w_ready),
		.b_resp_o(uart_b_resp), .b_valid_o(uart_b_valid), .b_ready_i(uart_b_ready),
		.tx_data_o(uart_tx_data_o), .tx_valid_o(uart_tx_valid_o)
	);

	axi_clint #(.ADDR_LEN(ADDR_LEN), .DATA_LEN(DATA_LEN)) u_clint (
		.clk(clk), .rst_n_i(rst_n_i),
		.ar_addr_i(clint_ar_addr), .ar_valid_i(clint_ar_valid), .ar_ready_o(clint_ar_ready),
		.r_data_o(clint_r_data), .r_resp_o(clint_r_resp), .r_valid_o(clint_r_valid),
		.r_ready_i(clint_r_ready)
	);

endmodule

`default_nettype wire

//--- hw/axi_clint.sv
// axi-lite clint slave: free-running 64-bit mtime, read as two halves
`default_nettype none

module axi_clint import soc_bus_pkg::*; #(
	parameter int ADDR_LEN = 32,
	parameter int DATA_LEN = 32
) (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic [ADDR_LEN-1:0] ar_addr_i,
	input  logic                ar_valid_i,
	output logic                ar_ready_o,
	output logic [DATA_LEN-1:0] r_data_o,
	output logic [1:0]          r_resp_o,
	output logic                r_valid_o,
	input  logic                r_ready_i
);

	logic [63:0]         mtime;
	logic                rd_hs;
	logic [DATA_LEN-1:0] r_data_q;
	logic                r_valid_q;

	assign ar_ready_o = ar_valid_i && !r_valid_q;
	assign rd_hs      = ar_valid_i && ar_ready_o;

	assign r_data_o  = r_data_q;
	assign r_resp_o  = RESP_OKAY;
	assign r_valid_o = r_valid_q;

	// counts every cycle, back-pressure or not
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			mtime <= '0;
		end else begin
			mtime <= mtime + 64'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_hs) begin
			// bit 2 picks the high word
			r_data_q <= DATA_LEN'(ar_addr_i[2] ? mtime[63:32] : mtime[31:0]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			r_valid_q <= 1'b0;
		end else if (rd_hs) begin
			r_valid_q <= 1'b1;
		end else if (r_ready_i) begin
			r_valid_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/axi_uart.sv
// axi-lite uart transmit slave: low data byte out as a one-cycle strobe per write
`default_nettype none

module axi_uart import soc_bus_pkg::*; #(
	parameter int DATA_LEN = 32
) (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                aw_valid_i,
	output logic                aw_ready_o,
	input  logic [DATA_LEN-1:0] w_data_i,
	input  logic                w_valid_i,
	output logic                w_ready_o,
	output logic [1:0]          b_resp_o,
	output logic                b_valid_o,
	input  logic                b_ready_i,
	output logic [7:0]          tx_data_o,
	output logic                tx_valid_o
);

	logic       wr_hs;
	logic       b_valid_q, tx_valid_q;
	logic [7:0] tx_data_q;

	assign aw_ready_o = aw_valid_i && w_valid_i && !b_valid_q;
	assign w_ready_o  = aw_ready_o;
	assign wr_hs      = aw_valid_i && aw_ready_o;

	assign b_resp_o   = RESP_OKAY;
	assign b_valid_o  = b_valid_q;
	assign tx_data_o  = tx_data_q;
	assign tx_valid_o = tx_valid_q;

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			tx_data_q <= w_data_i[7:0];	// strobes ignored
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			tx_valid_q <= 1'b0;
			b_valid_q  <= 1'b0;
		end else begin
			tx_valid_q <= wr_hs;	// single pulse, same cycle as b_valid
			if (wr_hs) begin
				b_valid_q <= 1'b1;
			end else if (b_ready_i) begin
				b_valid_q <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/axi_sram.sv
// axi-lite sram slave: word array with byte-strobe writes and one-cycle responses
`default_nettype none

module axi_sram import soc_bus_pkg::*; #(
	parameter int ADDR_LEN   = 32,
	parameter int DATA_LEN   = 32,
	parameter int SRAM_WORDS = 256
) (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic [ADDR_LEN-1:0]   ar_addr_i,
	input  logic                  ar_valid_i,
	output logic                  ar_ready_o,
	output logic [DATA_LEN-1:0]   r_data_o,
	output logic [1:0]            r_resp_o,
	output logic                  r_valid_o,
	input  logic                  r_ready_i,
	input  logic [ADDR_LEN-1:0]   aw_addr_i,
	input  logic                  aw_valid_i,
	output logic                  aw_ready_o,
	input  logic [DATA_LEN-1:0]   w_data_i,
	input  logic [DATA_LEN/8-1:0] w_strb_i,
	input  logic                  w_valid_i,
	output logic                  w_ready_o,
	output logic [1:0]            b_resp_o,
	output logic                  b_valid_o,
	input  logic                  b_ready_i
);

	localparam int IDX_LEN  = $clog2(SRAM_WORDS);
	localparam int STRB_LEN = DATA_LEN / 8;

	logic [DATA_LEN-1:0] mem [SRAM_WORDS];
	logic [ADDR_LEN-1:0] rd_off, wr_off;
	logic [IDX_LEN-1:0]  rd_idx, wr_idx;
	logic                rd_hs, wr_hs;
	logic [DATA_LEN-1:0] r_data_q;
	logic                r_valid_q, b_valid_q;

	// byte offset into the window, word index drops bits 1:0
	assign rd_off = ar_addr_i - ADDR_LEN'(SRAM_BASE);
	assign wr_off = aw_addr_i - ADDR_LEN'(SRAM_BASE);
	assign rd_idx = rd_off[IDX_LEN+1:2];
	assign wr_idx = wr_off[IDX_LEN+1:2];

	// no new request while a response waits
	assign ar_ready_o = ar_valid_i && !r_valid_q;
	assign aw_ready_o = aw_valid_i && w_valid_i && !b_valid_q;
	assign w_ready_o  = aw_ready_o;
	assign rd_hs      = ar_valid_i && ar_ready_o;
	assign wr_hs      = aw_valid_i && aw_ready_o;

	assign r_data_o  = r_data_q;
	assign r_resp_o  = RESP_OKAY;
	assign r_valid_o = r_valid_q;
	assign b_resp_o  = RESP_OKAY;
	assign b_valid_o = b_valid_q;

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			for (int i = 0; i < STRB_LEN; i++) begin
				if (w_strb_i[i]) begin
					mem[wr_idx][i*8 +: 8] <= w_data_i[i*8 +: 8];
				end
			end
		end
		if (rd_hs) begin
			r_data_q <= mem[rd_idx];	// old word on same-cycle write
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
		end else begin
			if (rd_hs) begin
				r_valid_q <= 1'b1;
			end else if (r_ready_i) begin
				r_valid_q <= 1'b0;
			end
			if (wr_hs) begin
				b_valid_q <= 1'b1;
			end else if (b_ready_i) begin
				b_valid_q <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/axi_xbar.sv
// axi-lite crossbar: steers cpu channels to sram, uart or clint, with a decerr responder
`default_nettype none

module axi_xbar import soc_bus_pkg::*; #(
	parameter int ADDR_LEN = 32,
	parameter int DATA_LEN = 32
) (
	input  logic                  clk,
	input  logic                  rst_n_i,
	// master side
	input  logic [ADDR_LEN-1:0]   cpu_ar_addr_i,
	input  logic                  cpu_ar_valid_i,
	output logic                  cpu_ar_ready_o,
	output logic [DATA_LEN-1:0]   cpu_r_data_o,
	output logic [1:0]            cpu_r_resp_o,
	output logic                  cpu_r_valid_o,
	input  logic                  cpu_r_ready_i,
	input  logic [ADDR_LEN-1:0]   cpu_aw_addr_i,
	input  logic                  cpu_aw_valid_i,
	output logic                  cpu_aw_ready_o,
	input  logic [DATA_LEN-1:0]   cpu_w_data_i,
	input  logic [DATA_LEN/8-1:0] cpu_w_strb_i,
	input  logic                  cpu_w_valid_i,
	output logic                  cpu_w_ready_o,
	output logic [1:0]            cpu_b_resp_o,
	output logic                  cpu_b_valid_o,
	input  logic                  cpu_b_ready_i,
	// selection from the decoder
	input  dev_t                  rd_dev_i,
	input  dev_t                  wr_dev_i,
	// sram
	output logic [ADDR_LEN-1:0]   sram_ar_addr_o,
	output logic                  sram_ar_valid_o,
	input  logic                  sram_ar_ready_i,
	input  logic [DATA_LEN-1:0]   sram_r_data_i,
	input  logic [1:0]            sram_r_resp_i,
	input  logic                  sram_r_valid_i,
	output logic                  sram_r_ready_o,
	output logic [ADDR_LEN-1:0]   sram_aw_addr_o,
	output logic                  sram_aw_valid_o,
	input  logic                  sram_aw_ready_i,
	output logic [DATA_LEN-1:0]   sram_w_data_o,
	output logic [DATA_LEN/8-1:0] sram_w_strb_o,
	output logic                  sram_w_valid_o,
	input  logic                  sram_w_ready_i,
	input  logic [1:0]            sram_b_resp_i,
	input  logic                  sram_b_valid_i,
	output logic                  sram_b_ready_o,
	// uart, write only
	output logic                  uart_aw_valid_o,
	input  logic                  uart_aw_ready_i,
	output logic [DATA_LEN-1:0]   uart_w_data_o,
	output logic                  uart_w_valid_o,
	input  logic                  uart_w_ready_i,
	input  logic [1:0]            uart_b_resp_i,
	input  logic                  uart_b_valid_i,
	output logic                  uart_b_ready_o,
	// clint, read only
	output logic [ADDR_LEN-1:0]   clint_ar_addr_o,
	output logic                  clint_ar_valid_o,
	input  logic                  clint_ar_ready_i,
	input  logic [DATA_LEN-1:0]   clint_r_data_i,
	input  logic [1:0]            clint_r_resp_i,
	input  logic                  clint_r_valid_i,
	output logic                  clint_r_ready_o
);

	logic rd_miss, wr_miss;		// nobody behind this address
	logic rd_err_q, wr_err_q;	// decerr response pending
	logic rd_err_hs, wr_err_hs;

	assign sram_ar_addr_o  = cpu_ar_addr_i;
	assign clint_ar_addr_o = cpu_ar_addr_i;
	assign sram_aw_addr_o  = cpu_aw_addr_i;
	assign sram_w_data_o   = cpu_w_data_i;
	assign sram_w_strb_o   = cpu_w_strb_i;
	assign uart_w_data_o   = cpu_w_data_i;

	// request valids and response readies go only to the selected slave
	assign sram_ar_valid_o  = cpu_ar_valid_i && (rd_dev_i == DEV_SRAM);
	assign sram_r_ready_o   = cpu_r_ready_i && (rd_dev_i == DEV_SRAM);
	assign clint_ar_valid_o = cpu_ar_valid_i && (rd_dev_i == DEV_CLINT);
	assign clint_r_ready_o  = cpu_r_ready_i && (rd_dev_i == DEV_CLINT);
	assign sram_aw_valid_o  = cpu_aw_valid_i && (wr_dev_i == DEV_SRAM);
	assign sram_w_valid_o   = cpu_w_valid_i && (wr_dev_i == DEV_SRAM);
	assign sram_b_ready_o   = cpu_b_ready_i && (wr_dev_i == DEV_SRAM);
	assign uart_aw_valid_o  = cpu_aw_valid_i && (wr_dev_i == DEV_UART);
	assign uart_w_valid_o   = cpu_w_valid_i && (wr_dev_i == DEV_UART);
	assign uart_b_ready_o   = cpu_b_ready_i && (wr_dev_i == DEV_UART);

	assign rd_miss   = !(rd_dev_i inside {DEV_SRAM, DEV_CLINT});
	assign wr_miss   = !(wr_dev_i inside {DEV_SRAM, DEV_UART});
	assign rd_err_hs = rd_miss && cpu_ar_valid_i && !rd_err_q;
	assign wr_err_hs = wr_miss && cpu_aw_valid_i && cpu_w_valid_i && !wr_err_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rd_err_q <= 1'b0;
			wr_err_q <= 1'b0;
		end else begin
			if (rd_err_hs) begin
				rd_err_q <= 1'b1;
			end else if (cpu_r_ready_i) begin
				rd_err_q <= 1'b0;
			end
			if (wr_err_hs) begin
				wr_err_q <= 1'b1;
			end else if (cpu_b_ready_i) begin
				wr_err_q <= 1'b0;
			end
		end
	end

	always_comb begin
		cpu_ar_ready_o = rd_err_hs;
		cpu_r_data_o   = '0;		// decerr reads return zero
		cpu_r_resp_o   = RESP_DECERR;
		cpu_r_valid_o  = rd_err_q;
		case (rd_dev_i)
			DEV_SRAM: begin
				cpu_ar_ready_o = sram_ar_ready_i;
				cpu_r_data_o   = sram_r_data_i;
				cpu_r_resp_o   = sram_r_resp_i;
				cpu_r_valid_o  = sram_r_valid_i;
			end
			DEV_CLINT: begin
				cpu_ar_ready_o = clint_ar_ready_i;
				cpu_r_data_o   = clint_r_data_i;
				cpu_r_resp_o   = clint_r_resp_i;
				cpu_r_valid_o  = clint_r_valid_i;
			end
			default: ;
		endcase
	end

	always_comb begin
		cpu_aw_ready_o = wr_err_hs;	// aw and w taken together
		cpu_w_ready_o  = wr_err_hs;
		cpu_b_resp_o   = RESP_DECERR;
		cpu_b_valid_o  = wr_err_q;
		case (wr_dev_i)
			DEV_SRAM: begin
				cpu_aw_ready_o = sram_aw_ready_i;
				cpu_w_ready_o  = sram_w_ready_i;
				cpu_b_resp_o   = sram_b_resp_i;
				cpu_b_valid_o  = sram_b_valid_i;
			end
			DEV_UART: begin
				cpu_aw_ready_o = uart_aw_ready_i;
				cpu_w_ready_o  = uart_w_ready_i;
				cpu_b_resp_o   = uart_b_resp_i;
				cpu_b_valid_o  = uart_b_valid_i;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/axi_addr_decode.sv
// address decoder: read and write device select with a latch per open transaction
`default_nettype none

module axi_addr_decode import soc_bus_pkg::*; #(
	parameter int ADDR_LEN   = 32,
	parameter int SRAM_WORDS = 256
) (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic [ADDR_LEN-1:0] ar_addr_i,
	input  logic                ar_valid_i,
	input  logic                ar_ready_i,
	input  logic                r_valid_i,
	input  logic                r_ready_i,
	input  logic [ADDR_LEN-1:0] aw_addr_i,
	input  logic                aw_valid_i,
	input  logic                aw_ready_i,
	input  logic                b_valid_i,
	input  logic                b_ready_i,
	output dev_t                rd_dev_o,
	output dev_t                wr_dev_o
);

	localparam logic [ADDR_LEN-1:0] SRAM_LO = ADDR_LEN'(SRAM_BASE);
	localparam logic [ADDR_LEN-1:0] SRAM_HI = ADDR_LEN'(SRAM_BASE + SRAM_WORDS * 4);

	logic rd_busy, wr_busy;
	dev_t rd_sel_q, wr_sel_q;
	dev_t rd_now, wr_now;

	// uart is write only, clint read only
	function automatic dev_t decode(input logic [ADDR_LEN-1:0] addr, input logic is_wr);
		logic sram_hit;
		sram_hit = (addr >= SRAM_LO) && (addr < SRAM_HI);
		if (sram_hit)
			return DEV_SRAM;
		if (addr == ADDR_LEN'(UART_TX_ADDR))
			return is_wr ? DEV_UART : DEV_NONE;
		if (addr == ADDR_LEN'(CLINT_MTIME_LO) || addr == ADDR_LEN'(CLINT_MTIME_HI))
			return is_wr ? DEV_NONE : DEV_CLINT;
		return DEV_NONE;
	endfunction

	assign rd_now = decode(ar_addr_i, 1'b0);
	assign wr_now = decode(aw_addr_i, 1'b1);

	// follow the address while idle, frozen while a response is owed
	assign rd_dev_o = rd_busy ? rd_sel_q : rd_now;
	assign wr_dev_o = wr_busy ? wr_sel_q : wr_now;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rd_busy  <= 1'b0;
			rd_sel_q <= DEV_NONE;
			wr_busy  <= 1'b0;
			wr_sel_q <= DEV_NONE;
		end else begin
			if (r_valid_i && r_ready_i) begin
				rd_busy <= 1'b0;	// response done, release
			end else if (ar_valid_i && ar_ready_i) begin
				rd_busy  <= 1'b1;
				rd_sel_q <= rd_now;
			end
			if (b_valid_i && b_ready_i) begin
				wr_busy <= 1'b0;
			end else if (aw_valid_i && aw_ready_i) begin
				wr_busy  <= 1'b1;
				wr_sel_q <= wr_now;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/soc_bus_pkg.sv
// soc bus package: device select enum, axi response codes, peripheral address map
`default_nettype none

package soc_bus_pkg;

	// destination of a request, as picked by the address decoder
	typedef enum logic [1:0] {
		DEV_NONE  = 2'd0,	// unmapped or unsupported, crossbar answers
		DEV_SRAM  = 2'd1,
		DEV_UART  = 2'd2,
		DEV_CLINT = 2'd3
	} dev_t;

	// axi-lite response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// sram window starts here, size comes from SRAM_WORDS
	localparam logic [31:0] SRAM_BASE = 32'h8000_0000;

	// uart transmit holding register, write only
	localparam logic [31:0] UART_TX_ADDR = 32'ha000_03f8;

	// clint mtime halves, read only
	localparam logic [31:0] CLINT_MTIME_LO = 32'ha000_0048;
	localparam logic [31:0] CLINT_MTIME_HI = 32'ha000_004c;

endpackage

`default_nettype wire
